//--- rtl/fpu_ncp_consts.svh
`ifndef FPU_NCP_CONSTS_SVH
`define FPU_NCP_CONSTS_SVH

// Datapath sizing
`define NUM_LANES      2
`define TAG_BITS       4
`define FIFO_DEPTH     4

// Instruction field widths
`define INST_FPU_BITS  4
`define INST_MOD_BITS  3

// Opcodes handled by this unit
`define INST_FPU_CLASS 4'd11
`define INST_FPU_CMP   4'd12
`define INST_FPU_MISC  4'd14

`endif

//--- rtl/fpu_ncp_pkg.sv
package fpu_ncp_pkg;

    // Internal operation after decode
    typedef enum logic [3:0] {
        SGNJ  = 4'd0,
        SGNJN = 4'd1,
        SGNJX = 4'd2,
        MIN   = 4'd3,
        MAX   = 4'd4,
        FLE   = 4'd5,
        FLT   = 4'd6,
        FEQ   = 4'd7,
        CLASS = 4'd8
    } ncp_op_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] man;
    } fp32_fields_t;

    // Field view for classify, raw view for ordering and results
    typedef union packed {
        fp32_fields_t f;
        logic [31:0]  raw;
    } fp32_u;

    // RISC-V fflags bit order
    typedef struct packed {
        logic nv; // Invalid
        logic dz; // Divide by zero
        logic of; // Overflow
        logic uf; // Underflow
        logic nx; // Inexact
    } fflags_t;

endpackage

//--- rtl/fpu_req_if.sv
`include "fpu_ncp_consts.svh"

interface fpu_req_if import fpu_ncp_pkg::*; ();

    logic                         valid;
    logic                         ready;
    logic [`TAG_BITS-1:0]         tag;
    ncp_op_e                      op;
    logic                         has_fflags;
    fp32_u [`NUM_LANES-1:0]       a;
    fp32_u [`NUM_LANES-1:0]       b;

    modport source (
        output valid, tag, op, has_fflags, a, b,
        input  ready
    );

    modport sink (
        input  valid, tag, op, has_fflags, a, b,
        output ready
    );

endinterface

//--- rtl/fpu_ncp_decode.sv
`include "fpu_ncp_consts.svh"

module fpu_ncp_decode import fpu_ncp_pkg::*; (
    input  logic [`INST_FPU_BITS-1:0]        op_type_i,
    input  logic [`INST_MOD_BITS-1:0]        frm_i,
    input  logic                             valid_i,
    input  logic [`TAG_BITS-1:0]             tag_i,
    input  logic [`NUM_LANES-1:0][31:0]      dataa_i,
    input  logic [`NUM_LANES-1:0][31:0]      datab_i,
    output logic                             ready_o,
    fpu_req_if.source                        req
);

    ncp_op_e op;
    logic    has_fflags;

    always_comb begin
        op         = SGNJ;
        has_fflags = 1'b0;
        case (op_type_i)
            `INST_FPU_MISC: begin
                case (frm_i)
                    3'd0: op = SGNJ;
                    3'd1: op = SGNJN;
                    3'd2: op = SGNJX;
                    3'd3: begin
                        op         = MIN;
                        has_fflags = 1'b1;
                    end
                    3'd4: begin
                        op         = MAX;
                        has_fflags = 1'b1;
                    end
                    default: op = SGNJ;
                endcase
            end
            `INST_FPU_CMP: begin
                has_fflags = 1'b1;
                case (frm_i)
                    3'd0:    op = FLE;
                    3'd1:    op = FLT;
                    default: op = FEQ; // frm 2 and unused codes
                endcase
            end
            `INST_FPU_CLASS: begin
                op = CLASS;
            end
            default: begin
                op         = SGNJ; // Unsupported opcode
                has_fflags = 1'b0;
            end
        endcase
    end

    assign req.valid      = valid_i;
    assign req.tag        = tag_i;
    assign req.op         = op;
    assign req.has_fflags = has_fflags;
    assign req.a          = dataa_i;
    assign req.b          = datab_i;

    assign ready_o = req.ready; // FIFO not full

endmodule

//--- rtl/fpu_ncp_fifo.sv
`include "fpu_ncp_consts.svh"

module fpu_ncp_fifo import fpu_ncp_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    fpu_req_if.sink   wr,
    fpu_req_if.source rd
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`FIFO_DEPTH);

    logic [`TAG_BITS-1:0]   tag_mem [`FIFO_DEPTH];
    ncp_op_e                op_mem  [`FIFO_DEPTH];
    logic                   hf_mem  [`FIFO_DEPTH];
    fp32_u [`NUM_LANES-1:0] a_mem   [`FIFO_DEPTH];
    fp32_u [`NUM_LANES-1:0] b_mem   [`FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr, do_rd;

    assign wr.ready = (count != FULL_CNT);
    assign rd.valid = (count != '0);
    assign do_wr    = wr.valid & wr.ready;
    assign do_rd    = rd.valid & rd.ready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            tag_mem[wr_ptr] <= wr.tag;
            op_mem[wr_ptr]  <= wr.op;
            hf_mem[wr_ptr]  <= wr.has_fflags;
            a_mem[wr_ptr]   <= wr.a;
            b_mem[wr_ptr]   <= wr.b;
        end
    end

    assign rd.tag        = tag_mem[rd_ptr];
    assign rd.op         = op_mem[rd_ptr];
    assign rd.has_fflags = hf_mem[rd_ptr];
    assign rd.a          = a_mem[rd_ptr];
    assign rd.b          = b_mem[rd_ptr];

endmodule

//--- rtl/fpu_ncp_lane.sv
module fpu_ncp_lane import fpu_ncp_pkg::*; (
    input  ncp_op_e     op_i,
    input  fp32_u       a_i,
    input  fp32_u       b_i,
    output logic [31:0] res_o,
    output logic        nv_o
);

    localparam logic [31:0] CANON_NAN = 32'h7FC0_0000;

    // RISC-V fclass mask
    function automatic logic [9:0] class_mask(input fp32_u x);
        logic       exp_zero;
        logic       exp_ones;
        logic       man_zero;
        logic [9:0] m;
        exp_zero = (x.f.exp == 8'h00);
        exp_ones = (x.f.exp == 8'hFF);
        man_zero = (x.f.man == 23'd0);
        m[0] =  x.f.sign & exp_ones & man_zero;   // -inf
        m[1] =  x.f.sign & !exp_zero & !exp_ones; // -normal
        m[2] =  x.f.sign & exp_zero & !man_zero;  // -subnormal
        m[3] =  x.f.sign & exp_zero & man_zero;   // -0
        m[4] = !x.f.sign & exp_zero & man_zero;   // +0
        m[5] = !x.f.sign & exp_zero & !man_zero;
        m[6] = !x.f.sign & !exp_zero & !exp_ones;
        m[7] = !x.f.sign & exp_ones & man_zero;
        m[8] = exp_ones & !man_zero & !x.f.man[22]; // Signalling NaN
        m[9] = exp_ones & x.f.man[22];              // Quiet NaN
        return m;
    endfunction

    logic [9:0] cls_a, cls_b;
    logic       a_nan, b_nan;
    logic       a_snan, b_snan;
    logic       both_zero;
    logic       ord_lt;
    logic       feq, flt;

    assign cls_a     = class_mask(a_i);
    assign cls_b     = class_mask(b_i);
    assign a_nan     = cls_a[8] | cls_a[9];
    assign b_nan     = cls_b[8] | cls_b[9];
    assign a_snan    = cls_a[8];
    assign b_snan    = cls_b[8];
    assign both_zero = (cls_a[3] | cls_a[4]) & (cls_b[3] | cls_b[4]);

    // Sign-magnitude order, -0 sorts below +0
    always_comb begin
        if (a_i.f.sign != b_i.f.sign) begin
            ord_lt = a_i.f.sign;
        end else if (a_i.f.sign) begin
            ord_lt = a_i.raw[30:0] > b_i.raw[30:0];
        end else begin
            ord_lt = a_i.raw[30:0] < b_i.raw[30:0];
        end
    end

    assign feq = !a_nan & !b_nan & ((a_i.raw == b_i.raw) | both_zero);
    assign flt = !a_nan & !b_nan & ord_lt & !both_zero;

    always_comb begin
        res_o = a_i.raw;
        nv_o  = 1'b0;
        case (op_i)
            SGNJ:  res_o = {b_i.f.sign, a_i.raw[30:0]};
            SGNJN: res_o = {~b_i.f.sign, a_i.raw[30:0]};
            SGNJX: res_o = {a_i.f.sign ^ b_i.f.sign, a_i.raw[30:0]};
            MIN, MAX: begin
                nv_o = a_snan | b_snan;
                if (a_nan && b_nan) begin
                    res_o = CANON_NAN;
                end else if (a_nan) begin
                    res_o = b_i.raw;
                end else if (b_nan) begin
                    res_o = a_i.raw;
                end else if (ord_lt ^ (op_i == MAX)) begin
                    res_o = a_i.raw;
                end else begin
                    res_o = b_i.raw;
                end
            end
            FLE: begin
                res_o = {31'd0, flt | feq};
                nv_o  = a_nan | b_nan;
            end
            FLT: begin
                res_o = {31'd0, flt};
                nv_o  = a_nan | b_nan;
            end
            FEQ: begin
                res_o = {31'd0, feq};
                nv_o  = a_snan | b_snan; // Quiet compare
            end
            CLASS:   res_o = {22'd0, cls_a};
            default: res_o = a_i.raw;
        endcase
    end

endmodule

//--- rtl/fpu_ncp_unit.sv
`include "fpu_ncp_consts.svh"

module fpu_ncp_unit import fpu_ncp_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    fpu_req_if.sink                      req,
    input  logic                         ready_i,
    output logic                         valid_o,
    output logic [`TAG_BITS-1:0]         tag_o,
    output logic [`NUM_LANES-1:0][31:0]  result_o,
    output logic                         has_fflags_o,
    output fflags_t [`NUM_LANES-1:0]     fflags_o
);

    logic [`NUM_LANES-1:0][31:0] lane_res;
    logic [`NUM_LANES-1:0]       lane_nv;
    fflags_t [`NUM_LANES-1:0]    fflags_d;
    logic                        accept;

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        fpu_ncp_lane lane_inst (
            .op_i  (req.op),
            .a_i   (req.a[i]),
            .b_i   (req.b[i]),
            .res_o (lane_res[i]),
            .nv_o  (lane_nv[i])
        );
        assign fflags_d[i] = '{nv: lane_nv[i] & req.has_fflags, default: 1'b0};
    end

    assign req.ready = !valid_o || ready_i; // Empty or draining
    assign accept    = req.valid & req.ready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (accept) begin
            valid_o <= 1'b1;
        end else if (ready_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tag_o        <= req.tag;
            result_o     <= lane_res;
            has_fflags_o <= req.has_fflags;
            fflags_o     <= fflags_d;
        end
    end

endmodule

//--- rtl/fpu_ncp_top.sv
`include "fpu_ncp_consts.svh"

module fpu_ncp_top import fpu_ncp_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         valid_i,
    output logic                         ready_o,
    input  logic [`TAG_BITS-1:0]         tag_i,
    input  logic [`INST_FPU_BITS-1:0]    op_type_i,
    input  logic [`INST_MOD_BITS-1:0]    frm_i,
    input  logic [`NUM_LANES-1:0][31:0]  dataa_i,
    input  logic [`NUM_LANES-1:0][31:0]  datab_i,
    input  logic                         ready_i,
    output logic                         valid_o,
    output logic [`TAG_BITS-1:0]         tag_o,
    output logic [`NUM_LANES-1:0][31:0]  result_o,
    output logic                         has_fflags_o,
    output fflags_t [`NUM_LANES-1:0]     fflags_o
);

    fpu_req_if req_dec ();
    fpu_req_if req_q ();

    fpu_ncp_decode decode_inst (
        .op_type_i (op_type_i),
        .frm_i     (frm_i),
        .valid_i   (valid_i),
        .tag_i     (tag_i),
        .dataa_i   (dataa_i),
        .datab_i   (datab_i),
        .ready_o   (ready_o),
        .req       (req_dec)
    );

    fpu_ncp_fifo fifo_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .wr      (req_dec),
        .rd      (req_q)
    );

    fpu_ncp_unit unit_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req          (req_q),
        .ready_i      (ready_i),
        .valid_o      (valid_o),
        .tag_o        (tag_o),
        .result_o     (result_o),
        .has_fflags_o (has_fflags_o),
        .fflags_o     (fflags_o)
    );

endmodule

//--- testbench/fpu_ncp_clkgen.sv
module fpu_ncp_clkgen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #4 clk_o = ~clk_o; // 8 unit period

endmodule

//--- testbench/fpu_ncp_assert.sv
`include "fpu_ncp_consts.svh"

module fpu_ncp_assert import fpu_ncp_pkg::*; (
    input logic                         clk_i,
    input logic                         rst_n_i,
    input logic                         ready_i,
    input logic                         out_valid_i,
    input logic [`TAG_BITS-1:0]         out_tag_i,
    input logic [`NUM_LANES-1:0][31:0]  out_result_i,
    input logic                         head_valid_i,
    input ncp_op_e                      head_op_i,
    input logic                         head_hf_i
);

    logic head_flag_op;

    assign head_flag_op = (head_op_i == MIN) || (head_op_i == MAX) || (head_op_i == FLE)
                       || (head_op_i == FLT) || (head_op_i == FEQ);

    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
        else $error("valid_o high during reset");

    stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_i && !ready_i |=> out_valid_i && $stable(out_tag_i) && $stable(out_result_i))
        else $error("Output changed while stalled");

    head_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        head_valid_i && !head_flag_op |-> !head_hf_i)
        else $error("has_fflags set on FIFO head for a flag-free operation");

endmodule

bind fpu_ncp_top fpu_ncp_assert fpu_ncp_assert_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ready_i      (ready_i),
    .out_valid_i  (valid_o),
    .out_tag_i    (tag_o),
    .out_result_i (result_o),
    .head_valid_i (req_q.valid),
    .head_op_i    (req_q.op),
    .head_hf_i    (req_q.has_fflags)
);

//--- testbench/fpu_ncp_tb.sv
`include "fpu_ncp_consts.svh"

module fpu_ncp_tb;

    localparam int NUM_REQ   = 390;
    localparam int MAX_CYCLE = 4 * NUM_REQ + 200;

    typedef struct packed {
        logic [`TAG_BITS-1:0]        tag;
        logic [`NUM_LANES-1:0][31:0] res;
        logic [`NUM_LANES-1:0][4:0]  ff;
        logic                        hf;
    } expect_t;

    logic                        clk, rst_n_i, valid_i, ready_o, ready_i;
    logic [`TAG_BITS-1:0]        tag_i, tag_o;
    logic [3:0]                  op_type_i;
    logic [2:0]                  frm_i;
    logic [`NUM_LANES-1:0][31:0] dataa_i, datab_i, result_o;
    logic                        valid_o, has_fflags_o;
    logic [`NUM_LANES-1:0][4:0]  fflags_o;
    logic                        bp_mode;
    int unsigned                 seed;
    int                          sent_cnt, cycle_cnt;
    expect_t                     exp_q[$];

    fpu_ncp_clkgen clkgen_inst (.clk_o(clk));

    fpu_ncp_top fpu_ncp_top_inst (
        .clk_i(clk), .rst_n_i(rst_n_i), .valid_i(valid_i), .ready_o(ready_o),
        .tag_i(tag_i), .op_type_i(op_type_i), .frm_i(frm_i),
        .dataa_i(dataa_i), .datab_i(datab_i), .ready_i(ready_i),
        .valid_o(valid_o), .tag_o(tag_o), .result_o(result_o),
        .has_fflags_o(has_fflags_o), .fflags_o(fflags_o)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // Total order, -0 just below +0
    function automatic logic signed [32:0] order_key(input logic [31:0] x);
        logic signed [32:0] mag;
        mag = {2'b00, x[30:0]};
        return x[31] ? -mag - 33'sd1 : mag;
    endfunction

    function automatic logic [9:0] class_of(input logic [31:0] x);
        int idx;
        if (x[30:23] == 8'hFF && x[22:0] != 23'd0) idx = x[22] ? 9 : 8;
        else if (x[30:23] == 8'hFF) idx = x[31] ? 0 : 7;
        else if (x[30:0] == 31'd0) idx = x[31] ? 3 : 4;
        else if (x[30:23] == 8'h00) idx = x[31] ? 2 : 5;
        else idx = x[31] ? 1 : 6;
        return 10'd1 << idx;
    endfunction

    // 0-2 sign inject, 3 min, 4 max, 5 fle, 6 flt, 7 feq, 8 class
    function automatic int decode_op(input logic [3:0] opc, input logic [2:0] frm);
        if (opc == `INST_FPU_MISC) return (frm <= 3'd4) ? int'(frm) : 0;
        if (opc == `INST_FPU_CMP) return (frm <= 3'd1) ? 5 + int'(frm) : 7;
        if (opc == `INST_FPU_CLASS) return 8;
        return 0;
    endfunction

    // Returns {nv, result}
    function automatic logic [32:0] ref_lane(input int op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic an, bn, sn, zz, lt, eq;
        an = is_nan(a);
        bn = is_nan(b);
        sn = is_snan(a) || is_snan(b);
        zz = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
        lt = !an && !bn && !zz && (order_key(a) < order_key(b));
        eq = !an && !bn && (zz || a == b);
        case (op)
            0: return {1'b0, b[31], a[30:0]};
            1: return {1'b0, ~b[31], a[30:0]};
            2: return {1'b0, a[31] ^ b[31], a[30:0]};
            3, 4: begin
                if (an && bn) return {sn, 32'h7FC0_0000};
                if (an) return {sn, b};
                if (bn) return {sn, a};
                if ((order_key(a) < order_key(b)) == (op == 3)) return {sn, a};
                return {sn, b};
            end
            5: return {an || bn, 31'd0, lt || eq};
            6: return {an || bn, 31'd0, lt};
            7: return {sn, 31'd0, eq};
            default: return {1'b0, 22'd0, class_of(a)};
        endcase
    endfunction

    function automatic logic [31:0] rand_operand();
        logic s;
        s = 1'($urandom);
        case ($urandom % 8)
            0: return {s, 31'd0};
            1: return {s, 8'hFF, 23'd0};                       // Infinity
            2: return {s, 8'hFF, 1'b1, 22'($urandom)};         // Quiet NaN
            3: return {s, 8'hFF, 1'b0, 22'($urandom) | 22'd1}; // Signalling NaN
            4: return {s, 8'h00, 23'($urandom) | 23'd1};       // Subnormal
            5: return {s, 8'h7F, 20'd0, 3'($urandom)};         // Near one, collides often
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [3:0] mixed_opcode();
        case ($urandom % 3)
            0: return `INST_FPU_MISC;
            1: return `INST_FPU_CMP;
            default: return `INST_FPU_CLASS;
        endcase
    endfunction

    task automatic send_req(input logic [3:0] opc, input logic [2:0] frm);
        expect_t     e;
        logic [32:0] r;
        int          op;
        logic        accepted;
        op        = decode_op(opc, frm);
        valid_i   = 1'b1;
        tag_i     = `TAG_BITS'(sent_cnt);
        op_type_i = opc;
        frm_i     = frm;
        e.tag     = tag_i;
        e.hf      = (op >= 3) && (op <= 7);
        for (int i = 0; i < `NUM_LANES; i++) begin
            dataa_i[i] = rand_operand();
            datab_i[i] = ($urandom % 8 == 0) ? dataa_i[i] : rand_operand();
            r          = ref_lane(op, dataa_i[i], datab_i[i]);
            e.res[i]   = r[31:0];
            e.ff[i]    = {r[32] & e.hf, 4'b0000};
        end
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = ready_o;
            @(posedge clk);
            #1;
        end
        exp_q.push_back(e);
        sent_cnt++;
    endtask

    always @(posedge clk) begin
        #1;
        ready_i = bp_mode ? 1'($urandom) : 1'b1;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt < MAX_CYCLE)
            else report_failure($sformatf("Timeout after %0d cycles", cycle_cnt));
    end

    always @(negedge clk) begin : compare
        expect_t e;
        if (rst_n_i && valid_o && ready_i) begin
            assert (exp_q.size() != 0)
                else report_failure("Result came out with no request outstanding");
            e = exp_q.pop_front();
            assert (tag_o == e.tag) else report_failure(
                $sformatf("MISMATCH tag_o: got 0x%h expected 0x%h", tag_o, e.tag));
            assert (result_o == e.res) else report_failure(
                $sformatf("MISMATCH result_o: got 0x%h expected 0x%h", result_o, e.res));
            assert (fflags_o == e.ff) else report_failure(
                $sformatf("MISMATCH fflags_o: got 0x%h expected 0x%h", fflags_o, e.ff));
            assert (has_fflags_o == e.hf) else report_failure(
                $sformatf("MISMATCH has_fflags_o: got 0x%h expected 0x%h", has_fflags_o, e.hf));
        end
    end

    initial begin
        seed      = $urandom(22540);
        rst_n_i   = 1'b0;
        valid_i   = 1'b0;
        tag_i     = '0;
        op_type_i = '0;
        frm_i     = '0;
        dataa_i   = '0;
        datab_i   = '0;
        ready_i   = 1'b0;
        bp_mode   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        assert (ready_o && !valid_o) else report_failure("Handshake outputs wrong after reset");
        for (int n = 0; n < 60; n++) send_req(`INST_FPU_MISC, 3'(n % 3));
        for (int n = 0; n < 60; n++) send_req(`INST_FPU_MISC, 3'(3 + n % 2));
        for (int n = 0; n < 90; n++) send_req(`INST_FPU_CMP, 3'(n % 3));
        for (int n = 0; n < 40; n++) send_req(`INST_FPU_CLASS, 3'($urandom));
        bp_mode = 1'b1; // Random stalls on the output
        for (int n = 0; n < 100; n++) send_req(mixed_opcode(), 3'($urandom));
        bp_mode = 1'b0;
        for (int n = 0; n < 40; n++) begin
            case (n % 4)
                0: send_req(`INST_FPU_MISC, 3'(5 + n % 3));
                1: send_req(`INST_FPU_CMP, 3'(3 + n % 5));
                2: send_req(4'(n % 11), 3'($urandom));
                default: send_req((n % 8 == 3) ? 4'd13 : 4'd15, 3'($urandom));
            endcase
        end
        valid_i = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (ready_o && !valid_o)
            else report_failure("DUT not idle after the last result");
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- fpu_ncp.f
+incdir+rtl
rtl/fpu_ncp_pkg.sv
rtl/fpu_req_if.sv
rtl/fpu_ncp_decode.sv
rtl/fpu_ncp_fifo.sv
rtl/fpu_ncp_lane.sv
rtl/fpu_ncp_unit.sv
rtl/fpu_ncp_top.sv
testbench/fpu_ncp_clkgen.sv
testbench/fpu_ncp_assert.sv
testbench/fpu_ncp_tb.sv

//--- Makefile
SIM := obj_dir/Vfpu_ncp_tb

.PHONY: all run clean

all: run

$(SIM): fpu_ncp.f $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)
	verilator --binary --assert -Wno-fatal --top-module fpu_ncp_tb -f fpu_ncp.f

run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TEST FAIL" sim.log
	grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log
